// File: source/exu_pkg.sv
package exu_pkg;

  localparam int XLEN = 32;

  // ======================================================================
  // Major opcodes and operation codes
  // ======================================================================
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU, SGE, SGEU
  } alu_op_e;

  typedef enum logic [3:0] {
    PRIV   = 4'd0,
    CSRRW  = 4'd1,
    CSRRS  = 4'd2,
    CSRRC  = 4'd3,
    CSRRWI = 4'd5,
    CSRRSI = 4'd6,
    CSRRCI = 4'd7
  } sys_func_e;

  typedef enum logic [11:0] {
    ECALL  = 12'h000,
    EBREAK = 12'h001,
    MRET   = 12'h302
  } priv_code_e;

  // ======================================================================
  // Immediate word, plain or system view
  // ======================================================================
  typedef struct packed {
    logic [15:0] pad;
    logic [11:0] code;  // CSR address or privileged code
    sys_func_e   func;
  } sys_imm_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    sys_imm_t        sys;
  } imm_u;

endpackage

// File: source/csr_pkg.sv
package csr_pkg;

  // ======================================================================
  // Machine-mode CSR addresses
  // ======================================================================
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  // mstatus fields
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // MPP fixed at machine mode
  localparam logic [31:0] MSTATUS_RESET = 32'h0000_1800;

  // ======================================================================
  // Exception causes
  // ======================================================================
  localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

endpackage

// File: source/exu_op_if.sv
`timescale 1ns/10ps

interface exu_op_if;

  exu_pkg::opcode_e            opcode;
  exu_pkg::alu_op_e            alu_op;
  logic [exu_pkg::XLEN-1:0]    src1;
  logic [exu_pkg::XLEN-1:0]    src2;
  exu_pkg::imm_u               imm;
  logic [exu_pkg::XLEN-1:0]    pc;

  // Latched by the controller on issue
  modport ctrl (
    output opcode, alu_op, src1, src2, imm, pc
  );

  modport unit (
    input opcode, alu_op, src1, src2, imm, pc
  );

endinterface

// File: source/exu_alu_br.sv
`timescale 1ns/10ps

module exu_alu_br (
  exu_op_if.unit                   op,
  output logic [exu_pkg::XLEN-1:0] alu_res_o,
  output logic [exu_pkg::XLEN-1:0] npc_o
);

  localparam int XLEN = exu_pkg::XLEN;

  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] alu_core;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_imm;
  logic [XLEN-1:0] jalr_tgt;
  logic            br_taken;

  assign opb      = (op.opcode == exu_pkg::OP || op.opcode == exu_pkg::BRANCH) ?
                    op.src2 : op.imm.raw;
  assign pc_plus4 = op.pc + 32'd4;
  assign pc_imm   = op.pc + op.imm.raw;
  assign jalr_tgt = (op.src1 + op.imm.raw) & ~32'd1;

  always_comb begin
    case (op.alu_op)
      exu_pkg::ADD:  alu_core = op.src1 + opb;
      exu_pkg::SUB:  alu_core = op.src1 - opb;
      exu_pkg::XOR:  alu_core = op.src1 ^ opb;
      exu_pkg::OR:   alu_core = op.src1 | opb;
      exu_pkg::AND:  alu_core = op.src1 & opb;
      exu_pkg::SLL:  alu_core = op.src1 << opb[4:0];
      exu_pkg::SRL:  alu_core = op.src1 >> opb[4:0];
      exu_pkg::SRA:  alu_core = $signed(op.src1) >>> opb[4:0];
      exu_pkg::SLT:  alu_core = {{(XLEN-1){1'b0}}, $signed(op.src1) < $signed(opb)};
      exu_pkg::SLTU: alu_core = {{(XLEN-1){1'b0}}, op.src1 < opb};
      exu_pkg::SGE:  alu_core = {{(XLEN-1){1'b0}}, $signed(op.src1) >= $signed(opb)};
      exu_pkg::SGEU: alu_core = {{(XLEN-1){1'b0}}, op.src1 >= opb};
      default:       alu_core = '0;
    endcase
  end

  // BEQ compares by SUB, every other branch by a nonzero flag
  assign br_taken = (op.opcode == exu_pkg::BRANCH) &&
                    ((op.alu_op == exu_pkg::SUB) ? (alu_core == '0) : (alu_core != '0));

  always_comb begin
    case (op.opcode)
      exu_pkg::LUI:                alu_res_o = op.imm.raw;
      exu_pkg::AUIPC:              alu_res_o = pc_imm;
      exu_pkg::JAL, exu_pkg::JALR: alu_res_o = pc_plus4;  // Link address
      default:                     alu_res_o = alu_core;
    endcase
  end

  always_comb begin
    npc_o = pc_plus4;
    if (br_taken || op.opcode == exu_pkg::JAL) begin
      npc_o = pc_imm;
    end else if (op.opcode == exu_pkg::JALR) begin
      npc_o = jalr_tgt;
    end
  end

endmodule

// File: source/exu_csr.sv
`timescale 1ns/10ps

module exu_csr (
  input  logic                     clk,
  input  logic                     rst,
  exu_op_if.unit                   op,
  input  logic                     commit_i,
  input  logic [exu_pkg::XLEN-1:0] npc_alu_i,
  output logic [exu_pkg::XLEN-1:0] csr_rdata_o,
  output logic [exu_pkg::XLEN-1:0] npc_o
);

  localparam int XLEN = exu_pkg::XLEN;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] csr_wdata;
  logic            is_sys;
  logic            is_priv;
  logic            is_ecall;
  logic            is_mret;
  logic            csr_we;

  assign is_sys   = (op.opcode == exu_pkg::SYSTEM);
  assign is_priv  = is_sys && (op.imm.sys.func == exu_pkg::PRIV);
  assign is_ecall = is_priv && (op.imm.sys.code == exu_pkg::ECALL);
  assign is_mret  = is_priv && (op.imm.sys.code == exu_pkg::MRET);
  assign csr_we   = is_sys && !is_priv;

  // ======================================================================
  // Read path
  // ======================================================================
  always_comb begin
    case (op.imm.sys.code)
      csr_pkg::CSR_MSTATUS: csr_rdata_o = mstatus;
      csr_pkg::CSR_MTVEC:   csr_rdata_o = mtvec;
      csr_pkg::CSR_MEPC:    csr_rdata_o = mepc;
      csr_pkg::CSR_MCAUSE:  csr_rdata_o = mcause;
      default:              csr_rdata_o = '0;  // Unimplemented
    endcase
  end

  // Immediate forms arrive zero-extended in src1
  always_comb begin
    case (op.imm.sys.func)
      exu_pkg::CSRRW, exu_pkg::CSRRWI: csr_wdata = op.src1;
      exu_pkg::CSRRS, exu_pkg::CSRRSI: csr_wdata = csr_rdata_o | op.src1;
      exu_pkg::CSRRC, exu_pkg::CSRRCI: csr_wdata = csr_rdata_o & ~op.src1;
      default:                         csr_wdata = csr_rdata_o;
    endcase
  end

  // ======================================================================
  // Update at commit
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= csr_pkg::MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (csr_we) begin
        case (op.imm.sys.code)
          csr_pkg::CSR_MSTATUS: mstatus <= csr_wdata;
          csr_pkg::CSR_MTVEC:   mtvec   <= csr_wdata;
          csr_pkg::CSR_MEPC:    mepc    <= csr_wdata;
          csr_pkg::CSR_MCAUSE:  mcause  <= csr_wdata;
          default:              mcause  <= mcause;
        endcase
      end
      if (is_ecall) begin
        mepc   <= op.pc;
        mcause <= csr_pkg::CAUSE_ECALL_M;
        mstatus[csr_pkg::MSTATUS_MPIE] <= mstatus[csr_pkg::MSTATUS_MIE];
        mstatus[csr_pkg::MSTATUS_MIE]  <= 1'b0;
      end
      if (is_mret) begin
        mstatus[csr_pkg::MSTATUS_MIE]  <= mstatus[csr_pkg::MSTATUS_MPIE];
        mstatus[csr_pkg::MSTATUS_MPIE] <= 1'b1;
      end
    end
  end

  assign npc_o = is_ecall ? mtvec :
                 is_mret  ? mepc  : npc_alu_i;  // Trap entry and return

  a_csr_commit_only: assert property (@(posedge clk) disable iff (rst)
    !commit_i |=> $stable({mstatus, mtvec, mepc, mcause}));

endmodule

// File: source/exu_bus_timer.sv
`timescale 1ns/10ps

module exu_bus_timer #(
  parameter int BUS_TIMEOUT_CYCLES = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic run_i,
  output logic expired_o
);

  localparam int            CW   = $clog2(BUS_TIMEOUT_CYCLES + 1);
  localparam logic [CW-1:0] LAST = CW'(BUS_TIMEOUT_CYCLES - 1);

  logic [CW-1:0] count;

  always_ff @(posedge clk) begin
    if (rst || !run_i) begin
      count <= '0;
    end else if (count != LAST) begin
      count <= count + CW'(1);  // Saturate at the last cycle
    end
  end

  assign expired_o = run_i && (count == LAST);

  // Controller drops the cycle right after expiry
  a_expire_drop: assert property (@(posedge clk) disable iff (rst)
    expired_o |=> !run_i);

endmodule

// File: source/exu_ctrl.sv
`timescale 1ns/10ps

module exu_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  exu_pkg::opcode_e         opcode_i,
  input  exu_pkg::alu_op_e         alu_op_i,
  input  logic [4:0]               rd_i,
  input  logic                     rd_wen_i,
  input  logic [exu_pkg::XLEN-1:0] src1_i,
  input  logic [exu_pkg::XLEN-1:0] src2_i,
  input  exu_pkg::imm_u            imm_i,
  input  logic [exu_pkg::XLEN-1:0] pc_i,
  output logic                     result_valid_o,
  input  logic                     result_ready_i,
  output logic [4:0]               rd_o,
  output logic                     rd_wen_o,
  output logic [exu_pkg::XLEN-1:0] rd_data_o,
  output logic                     ebreak_o,
  output logic                     bus_err_o,
  exu_op_if.ctrl                   op,
  input  logic [exu_pkg::XLEN-1:0] alu_res_i,
  input  logic [exu_pkg::XLEN-1:0] csr_rdata_i,
  output logic                     commit_o,
  output logic                     timer_run_o,
  input  logic                     timer_expired_i,
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [exu_pkg::XLEN-1:0] wb_adr_o,
  output logic [exu_pkg::XLEN-1:0] wb_dat_o,
  input  logic [exu_pkg::XLEN-1:0] wb_dat_i,
  input  logic                     wb_ack_i
);

  localparam int XLEN = exu_pkg::XLEN;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_BUS  = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]      state;
  logic [4:0]      rd_q;
  logic            rd_wen_q;
  logic            bus_err_q;
  logic [XLEN-1:0] load_q;
  logic            is_mem;
  logic            is_ebreak;

  assign is_mem = (opcode_i == exu_pkg::LOAD) || (opcode_i == exu_pkg::STORE);

  // ======================================================================
  // Handshake FSM
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      bus_err_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (issue_valid_i) begin
            state     <= is_mem ? S_BUS : S_DONE;
            bus_err_q <= 1'b0;
          end
        end
        S_BUS: begin
          if (wb_ack_i) begin
            state <= S_DONE;
          end else if (timer_expired_i) begin
            state     <= S_DONE;  // Abandon the access
            bus_err_q <= 1'b1;
          end
        end
        S_DONE: begin
          if (result_ready_i) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i && issue_ready_o) begin
      op.opcode <= opcode_i;
      op.alu_op <= alu_op_i;
      op.src1   <= src1_i;
      op.src2   <= src2_i;
      op.imm    <= imm_i;
      op.pc     <= pc_i;
      rd_q      <= rd_i;
      rd_wen_q  <= rd_wen_i;
    end
    if (wb_cyc_o && wb_ack_i && !wb_we_o) load_q <= wb_dat_i;
  end

  assign issue_ready_o  = (state == S_IDLE);
  assign result_valid_o = (state == S_DONE);
  assign commit_o       = result_valid_o && result_ready_i;

  // ======================================================================
  // Wishbone master
  // ======================================================================
  assign wb_cyc_o    = (state == S_BUS);
  assign wb_stb_o    = wb_cyc_o;
  assign wb_we_o     = (op.opcode == exu_pkg::STORE);
  assign wb_adr_o    = op.src1 + op.imm.raw;
  assign wb_dat_o    = op.src2;
  assign timer_run_o = wb_cyc_o;

  // Result side
  assign is_ebreak = (op.opcode == exu_pkg::SYSTEM) && (op.imm.sys.func == exu_pkg::PRIV) &&
                     (op.imm.sys.code == exu_pkg::EBREAK);
  assign ebreak_o  = result_valid_o && is_ebreak;
  assign rd_o      = rd_q;
  assign rd_wen_o  = rd_wen_q && !bus_err_q;  // No write after a bus error
  assign bus_err_o = bus_err_q;

  always_comb begin
    case (op.opcode)
      exu_pkg::LOAD:   rd_data_o = load_q;
      exu_pkg::SYSTEM: rd_data_o = csr_rdata_i;
      default:         rd_data_o = alu_res_i;
    endcase
  end

  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_stb_o && !wb_ack_i && !timer_expired_i |=>
      wb_stb_o && wb_cyc_o && $stable({wb_we_o, wb_adr_o, wb_dat_o}));

  a_result_hold: assert property (@(posedge clk) disable iff (rst)
    result_valid_o && !result_ready_i |=>
      result_valid_o && $stable({rd_o, rd_wen_o, rd_data_o, ebreak_o, bus_err_o}));

endmodule

// File: source/exu_top.sv
`timescale 1ns/10ps

module exu_top #(
  parameter int BUS_TIMEOUT_CYCLES = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  // Issue side
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  exu_pkg::opcode_e         opcode_i,
  input  exu_pkg::alu_op_e         alu_op_i,
  input  logic [4:0]               rd_i,
  input  logic                     rd_wen_i,
  input  logic [exu_pkg::XLEN-1:0] src1_i,
  input  logic [exu_pkg::XLEN-1:0] src2_i,
  input  exu_pkg::imm_u            imm_i,
  input  logic [exu_pkg::XLEN-1:0] pc_i,
  // Result side
  output logic                     result_valid_o,
  input  logic                     result_ready_i,
  output logic [4:0]               rd_o,
  output logic                     rd_wen_o,
  output logic [exu_pkg::XLEN-1:0] rd_data_o,
  output logic [exu_pkg::XLEN-1:0] npc_o,
  output logic                     ebreak_o,
  output logic                     bus_err_o,
  // Wishbone
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [exu_pkg::XLEN-1:0] wb_adr_o,
  output logic [exu_pkg::XLEN-1:0] wb_dat_o,
  input  logic [exu_pkg::XLEN-1:0] wb_dat_i,
  input  logic                     wb_ack_i
);

  logic [exu_pkg::XLEN-1:0] alu_res;
  logic [exu_pkg::XLEN-1:0] npc_alu;
  logic [exu_pkg::XLEN-1:0] csr_rdata;
  logic                     commit;
  logic                     timer_run;
  logic                     timer_expired;

  exu_op_if op_if ();

  exu_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_o   (issue_ready_o),
    .opcode_i        (opcode_i),
    .alu_op_i        (alu_op_i),
    .rd_i            (rd_i),
    .rd_wen_i        (rd_wen_i),
    .src1_i          (src1_i),
    .src2_i          (src2_i),
    .imm_i           (imm_i),
    .pc_i            (pc_i),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .rd_o            (rd_o),
    .rd_wen_o        (rd_wen_o),
    .rd_data_o       (rd_data_o),
    .ebreak_o        (ebreak_o),
    .bus_err_o       (bus_err_o),
    .op              (op_if.ctrl),
    .alu_res_i       (alu_res),
    .csr_rdata_i     (csr_rdata),
    .commit_o        (commit),
    .timer_run_o     (timer_run),
    .timer_expired_i (timer_expired),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .wb_we_o         (wb_we_o),
    .wb_adr_o        (wb_adr_o),
    .wb_dat_o        (wb_dat_o),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_i        (wb_ack_i)
  );

  exu_alu_br u_alu_br (
    .op        (op_if.unit),
    .alu_res_o (alu_res),
    .npc_o     (npc_alu)
  );

  // Trap targets override the ALU next PC
  exu_csr u_csr (
    .clk         (clk),
    .rst         (rst),
    .op          (op_if.unit),
    .commit_i    (commit),
    .npc_alu_i   (npc_alu),
    .csr_rdata_o (csr_rdata),
    .npc_o       (npc_o)
  );

  exu_bus_timer #(
    .BUS_TIMEOUT_CYCLES (BUS_TIMEOUT_CYCLES)
  ) u_bus_timer (
    .clk       (clk),
    .rst       (rst),
    .run_i     (timer_run),
    .expired_o (timer_expired)
  );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// File: test/exu_tb.sv
`timescale 1ns/10ps

module exu_tb;

  localparam int N_TESTS     = 30;
  localparam int N_COLS      = 13;
  localparam int BUS_TIMEOUT = 16;
  localparam int MAX_CYCLES  = N_TESTS * (BUS_TIMEOUT + 40);

  logic        clk;
  logic        rst;
  logic        issue_valid_i;
  logic        issue_ready_o;
  logic [6:0]  opcode_raw;
  logic [3:0]  alu_op_raw;
  logic [4:0]  rd_i;
  logic        rd_wen_i;
  logic [31:0] src1_i;
  logic [31:0] src2_i;
  logic [31:0] imm_raw;
  logic [31:0] pc_i;
  logic        result_valid_o;
  logic        result_ready_i;
  logic [4:0]  rd_o;
  logic        rd_wen_o;
  logic [31:0] rd_data_o;
  logic [31:0] npc_o;
  logic        ebreak_o;
  logic        bus_err_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [31:0] wb_adr_o;
  logic [31:0] wb_dat_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;

  logic [31:0] stim [0:N_TESTS*N_COLS-1];
  logic [31:0] lfsr;
  logic [31:0] cur_dly;
  logic [31:0] cur_ldata;
  logic [31:0] cur_adr;
  logic [31:0] cur_wdat;
  logic [6:0]  cur_opcode;
  int          cyc_cnt;
  int          cycles;
  int          n_err;
  int          n_bad_tests;
  int          n_commits;
  bit          test_bad;

  tb_clock u_clock (.clk(clk));

  exu_top #(
    .BUS_TIMEOUT_CYCLES (BUS_TIMEOUT)
  ) dut (
    .clk            (clk),
    .rst            (rst),
    .issue_valid_i  (issue_valid_i),
    .issue_ready_o  (issue_ready_o),
    .opcode_i       (exu_pkg::opcode_e'(opcode_raw)),
    .alu_op_i       (exu_pkg::alu_op_e'(alu_op_raw)),
    .rd_i           (rd_i),
    .rd_wen_i       (rd_wen_i),
    .src1_i         (src1_i),
    .src2_i         (src2_i),
    .imm_i          (exu_pkg::imm_u'(imm_raw)),
    .pc_i           (pc_i),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .rd_o           (rd_o),
    .rd_wen_o       (rd_wen_o),
    .rd_data_o      (rd_data_o),
    .npc_o          (npc_o),
    .ebreak_o       (ebreak_o),
    .bus_err_o      (bus_err_o),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_o       (wb_dat_o),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i)
  );

  // Galois LFSR, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      n_err++;
      test_bad = 1'b1;
    end
  endtask

  // ======================================================================
  // Wishbone responder and bus checks
  // ======================================================================
  always @(negedge clk) begin
    if (!rst && wb_cyc_o) begin
      cyc_cnt++;
      check_val("wb_stb_o", wb_stb_o, 1);
      check_val("wb_we_o", wb_we_o, cur_opcode == 7'h23);
      check_val("wb_adr_o", wb_adr_o, cur_adr);
      if (cur_opcode == 7'h23) check_val("wb_dat_o", wb_dat_o, cur_wdat);
      if (cur_dly != 32'hFF && cyc_cnt == cur_dly + 1) begin
        wb_ack_i = 1'b1;
        wb_dat_i = cur_ldata;
      end
    end else begin
      wb_ack_i = 1'b0;
      wb_dat_i = '0;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic run_test(input int idx);
    logic [31:0] f [0:N_COLS-1];
    logic [31:0] snap [0:3];
    bit          have_snap;
    bit          taken;
    int          exp_cyc;
    for (int c = 0; c < N_COLS; c++) f[c] = stim[idx*N_COLS + c];
    test_bad  = 1'b0;
    have_snap = 1'b0;
    taken     = 1'b0;
    @(negedge clk);
    cur_opcode    = f[0][6:0];
    cur_dly       = f[6];
    cur_ldata     = f[7];
    cur_adr       = f[11];
    cur_wdat      = f[12];
    cyc_cnt       = 0;
    opcode_raw    = f[0][6:0];
    alu_op_raw    = f[1][3:0];
    imm_raw       = f[2];
    src1_i        = f[3];
    src2_i        = f[4];
    pc_i          = f[5];
    rd_i          = idx[4:0];
    rd_wen_i      = f[10][3];
    issue_valid_i = 1'b1;
    check_val("issue_ready_o", issue_ready_o, 1);
    @(negedge clk);
    issue_valid_i = 1'b0;
    while (!taken) begin
      lfsr           = lfsr_next(lfsr);
      result_ready_i = lfsr[0];
      // Off the bus the result must already be there
      if (!wb_cyc_o) check_val("result_valid_o", result_valid_o, 1);
      if (result_valid_o) begin
        check_val("issue_ready_o while busy", issue_ready_o, 0);
        if (have_snap) begin  // Held result must not move
          check_val("rd_data_o hold", rd_data_o, snap[0]);
          check_val("npc_o hold", npc_o, snap[1]);
          check_val("rd_o hold", rd_o, snap[2]);
          check_val("flags hold", {rd_wen_o, bus_err_o, ebreak_o}, snap[3]);
        end
        snap[0]   = rd_data_o;
        snap[1]   = npc_o;
        snap[2]   = rd_o;
        snap[3]   = {rd_wen_o, bus_err_o, ebreak_o};
        have_snap = 1'b1;
        if (result_ready_i) begin
          check_val("rd_data_o", rd_data_o, f[8]);
          check_val("npc_o", npc_o, f[9]);
          check_val("rd_o", rd_o, idx[4:0]);
          check_val("rd_wen_o", rd_wen_o, f[10][2]);
          check_val("bus_err_o", bus_err_o, f[10][1]);
          check_val("ebreak_o", ebreak_o, f[10][0]);
          if (cur_opcode == 7'h03 || cur_opcode == 7'h23) begin
            exp_cyc = (cur_dly == 32'hFF) ? BUS_TIMEOUT : cur_dly + 1;
          end else begin
            exp_cyc = 0;
          end
          check_val("wb_cyc_o cycles", cyc_cnt, exp_cyc);
          taken = 1'b1;
          n_commits++;
        end
      end
      if (!taken) @(negedge clk);
    end
    if (test_bad) n_bad_tests++;
    $display("test %0d opcode 0x%02h: %s", idx, cur_opcode, test_bad ? "FAILED" : "ok");
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    rst            = 1'b1;
    issue_valid_i  = 1'b0;
    opcode_raw     = 7'h13;
    alu_op_raw     = '0;
    rd_i           = '0;
    rd_wen_i       = 1'b0;
    src1_i         = '0;
    src2_i         = '0;
    imm_raw        = '0;
    pc_i           = '0;
    result_ready_i = 1'b0;
    wb_ack_i       = 1'b0;
    wb_dat_i       = '0;
    lfsr           = 32'h19f6_b494;
    cycles         = 0;
    cyc_cnt        = 0;
    n_err          = 0;
    n_bad_tests    = 0;
    n_commits      = 0;
    cur_dly        = '0;
    cur_ldata      = '0;
    cur_adr        = '0;
    cur_wdat       = '0;
    cur_opcode     = '0;
    for (int i = 0; i < N_TESTS*N_COLS; i++) stim[i] = 'x;
    $readmemh("test/exu_stimulus.txt", stim);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_bad = 1'b0;
    check_val("issue_ready_o after reset", issue_ready_o, 1);
    check_val("result_valid_o after reset", result_valid_o, 0);
    check_val("wb_cyc_o after reset", wb_cyc_o, 0);
    check_val("wb_stb_o after reset", wb_stb_o, 0);
    check_val("bus_err_o after reset", bus_err_o, 0);
    if ($isunknown(stim[N_TESTS*N_COLS-1])) begin
      $display("Stimulus file is missing or shorter than %0d tests", N_TESTS);
      n_err++;
    end else begin
      for (int t = 0; t < N_TESTS; t++) run_test(t);
    end
    $display("tests %0d, committed %0d, failed tests %0d, failed checks %0d",
             N_TESTS, n_commits, n_bad_tests, n_err);
    if (n_err == 0 && n_commits == N_TESTS) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
source/exu_pkg.sv
source/csr_pkg.sv
source/exu_op_if.sv
source/exu_alu_br.sv
source/exu_csr.sv
source/exu_bus_timer.sv
source/exu_ctrl.sv
source/exu_top.sv
test/tb_clock.sv
test/exu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module exu_tb -o exu_sim &&
out="$(./obj_dir/exu_sim)" &&
echo "$out" &&
echo "$out" | grep -qx "TEST PASSED" ||
{ echo "Simulation did not pass" >&2; exit 1; }

// File: test/exu_stimulus.txt
// opcode alu_op imm src1 src2 pc ack_dly load_data exp_rd exp_npc flags exp_adr exp_wdat
// flags: bit3 rd_wen_i, bit2 rd_wen_o, bit1 bus_err_o, bit0 ebreak_o; ack_dly FF never acks
33 0 00000000 00000010 00000022 00000100 0 0 00000032 00000104 C 0 0
33 1 00000000 00000005 00000007 00000104 0 0 FFFFFFFE 00000108 0 0 0
13 2 0F0F0F0F F0F0F0F0 00000000 00000108 0 0 FFFFFFFF 0000010C C 0 0
33 7 00000000 80000000 00000004 0000010C 0 0 F8000000 00000110 C 0 0
33 8 00000000 FFFFFFFF 00000001 00000110 0 0 00000001 00000114 C 0 0
13 9 00000001 FFFFFFFF 00000000 00000114 0 0 00000000 00000118 C 0 0
37 0 12345000 00000000 00000000 00000118 0 0 12345000 0000011C C 0 0
17 0 00001000 00000000 00000000 00000200 0 0 00001200 00000204 C 0 0
63 1 00000040 00000005 00000005 00000300 0 0 00000000 00000340 0 0 0
63 1 00000040 00000005 00000006 00000300 0 0 FFFFFFFF 00000304 0 0 0
63 8 FFFFFFF0 FFFFFFF0 00000003 00000400 0 0 00000001 000003F0 0 0 0
63 B 00000020 00000001 00000002 00000400 0 0 00000000 00000404 0 0 0
6F 0 00000800 00000000 00000000 00000500 0 0 00000504 00000D00 C 0 0
67 0 00000010 00001001 00000000 00000600 0 0 00000604 00001010 C 0 0
03 0 00000014 00002000 00000000 00000700 2 DEADBEEF DEADBEEF 00000704 C 00002014 0
23 0 FFFFFFFC 00003000 CAFEF00D 00000704 0 0 00002FFC 00000708 0 00002FFC CAFEF00D
03 0 00000000 00000010 00000000 00000708 5 12345678 12345678 0000070C C 00000010 0
73 0 00003002 00000000 00000000 00000800 0 0 00001800 00000804 C 0 0
73 0 00003051 00001000 00000000 00000804 0 0 00000000 00000808 C 0 0
73 0 00003052 00000084 00000000 00000808 0 0 00001000 0000080C C 0 0
73 0 00003053 00000004 00000000 0000080C 0 0 00001084 00000810 C 0 0
73 0 00003006 00000008 00000000 00000810 0 0 00001800 00000814 C 0 0
73 0 00000000 00000000 00000000 00000900 0 0 00000000 00001080 0 0 0
73 0 00003412 00000000 00000000 00001080 0 0 00000900 00001084 C 0 0
73 0 00003422 00000000 00000000 00001084 0 0 0000000B 00001088 C 0 0
73 0 00003020 00000000 00000000 00001088 0 0 00000000 00000900 0 0 0
73 0 00003002 00000000 00000000 00000900 0 0 00001888 00000904 C 0 0
73 0 00000010 00000000 00000000 00000904 0 0 00000000 00000908 1 0 0
23 0 00000008 00004000 55AA55AA 00000908 FF 0 00004008 0000090C A 00004008 55AA55AA
33 0 00000000 00000001 00000002 0000090C 0 0 00000003 00000910 C 0 0
